/* hw/exe_cfg.svh */
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// register word and HI/LO pair
`define EXE_WORD_W      32
`define EXE_DWORD_W     64

// destination address, also the variable shift amount
`define EXE_REG_ADDR_W  5

// operation code and result class
`define EXE_AOP_W       8
`define EXE_ATYPE_W     3

// two quotient bits per iteration
`define EXE_DIV_STEPS   16

`endif

/* hw/exe_isa_pkg.sv */
`default_nettype none

`include "exe_cfg.svh"

package exe_isa_pkg;

    // grouped by function, high nibble is the class
    typedef enum logic [`EXE_AOP_W-1:0] {
        AOP_NOP   = 8'h00,
        AOP_AND   = 8'h10,
        AOP_ANDI  = 8'h11,
        AOP_OR    = 8'h12,
        AOP_ORI   = 8'h13,
        AOP_XOR   = 8'h14,
        AOP_XORI  = 8'h15,
        AOP_NOR   = 8'h16,
        AOP_LUI   = 8'h17,
        AOP_ADD   = 8'h20,
        AOP_ADDI  = 8'h21,
        AOP_ADDU  = 8'h22,
        AOP_ADDIU = 8'h23,
        AOP_SUB   = 8'h24,
        AOP_SUBU  = 8'h25,
        AOP_SLT   = 8'h26,
        AOP_SLTI  = 8'h27,
        AOP_SLTU  = 8'h28,
        AOP_SLTIU = 8'h29,
        AOP_SLL   = 8'h30,
        AOP_SRL   = 8'h31,
        AOP_SRA   = 8'h32,
        AOP_SLLV  = 8'h33,
        AOP_SRLV  = 8'h34,
        AOP_SRAV  = 8'h35,
        AOP_MULT  = 8'h40,
        AOP_MULTU = 8'h41,
        AOP_DIV   = 8'h42,
        AOP_DIVU  = 8'h43
    } aluop_e;

    typedef enum logic [`EXE_ATYPE_W-1:0] {
        ATYPE_NONE, ATYPE_LOGIC, ATYPE_ARITH, ATYPE_SHIFT, ATYPE_HILO
    } alutype_e;

endpackage

`default_nettype wire

/* hw/exe_bus_pkg.sv */
`default_nettype none

`include "exe_cfg.svh"

package exe_bus_pkg;

    typedef logic [`EXE_WORD_W-1:0] word_t;

    typedef struct packed {
        word_t hi;      // remainder after a divide
        word_t lo;      // quotient
    } hilo_pair_t;

    // same 64 bits, product view or hi/lo view
    typedef union packed {
        logic [`EXE_DWORD_W-1:0] prod;
        hilo_pair_t              hl;
    } hilo_u;

    typedef struct packed {
        exe_isa_pkg::aluop_e         aluop;
        word_t                       src1;
        word_t                       src2;
        logic [`EXE_REG_ADDR_W-1:0]  wa;
        logic                        wreg;
    } exe_req_t;

    typedef struct packed {
        logic [`EXE_REG_ADDR_W-1:0]  wa;
        logic                        wreg;
        word_t                       wd;
        logic                        whilo;
        hilo_u                       hilo;
        logic                        ov;
    } exe_rsp_t;

    typedef struct packed {
        logic  start;
        logic  is_signed;
        word_t dividend;
        word_t divisor;
    } div_req_t;

endpackage

`default_nettype wire

/* hw/exe_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module exe_alu (
    input  exe_isa_pkg::aluop_e  aluop_i,
    input  exe_bus_pkg::word_t   src1_i,
    input  exe_bus_pkg::word_t   src2_i,
    output exe_bus_pkg::word_t   res_o,
    output logic                 ov_o
);

    localparam int W = `EXE_WORD_W;

    exe_bus_pkg::word_t          sum;
    exe_bus_pkg::word_t          diff;
    exe_bus_pkg::word_t          sra_full;
    exe_bus_pkg::word_t          sra_var;
    logic [`EXE_REG_ADDR_W-1:0]  shamt_v;
    logic                        slt_s;
    logic                        slt_u;
    logic                        is_sub;
    logic                        add_ov;
    logic                        sub_ov;

    assign sum  = src1_i + src2_i;
    assign diff = src1_i + ~src2_i + 1'b1;     // two's complement subtract

    assign slt_s = $signed(src1_i) < $signed(src2_i);
    assign slt_u = src1_i < src2_i;

    // variable shifts use only the low bits of rs
    assign shamt_v  = src1_i[`EXE_REG_ADDR_W-1:0];
    assign sra_full = $signed(src2_i) >>> src1_i;
    assign sra_var  = $signed(src2_i) >>> shamt_v;

    always_comb begin
        case (aluop_i)
            exe_isa_pkg::AOP_AND,
            exe_isa_pkg::AOP_ANDI:  res_o = src1_i & src2_i;
            exe_isa_pkg::AOP_OR,
            exe_isa_pkg::AOP_ORI:   res_o = src1_i | src2_i;
            exe_isa_pkg::AOP_XOR,
            exe_isa_pkg::AOP_XORI:  res_o = src1_i ^ src2_i;
            exe_isa_pkg::AOP_NOR:   res_o = ~(src1_i | src2_i);
            exe_isa_pkg::AOP_LUI:   res_o = src2_i;   // immediate arrives pre-shifted
            exe_isa_pkg::AOP_ADD,
            exe_isa_pkg::AOP_ADDI,
            exe_isa_pkg::AOP_ADDU,
            exe_isa_pkg::AOP_ADDIU: res_o = sum;
            exe_isa_pkg::AOP_SUB,
            exe_isa_pkg::AOP_SUBU:  res_o = diff;
            exe_isa_pkg::AOP_SLT,
            exe_isa_pkg::AOP_SLTI:  res_o = {{(W-1){1'b0}}, slt_s};
            exe_isa_pkg::AOP_SLTU,
            exe_isa_pkg::AOP_SLTIU: res_o = {{(W-1){1'b0}}, slt_u};
            exe_isa_pkg::AOP_SLL:   res_o = src2_i << src1_i;
            exe_isa_pkg::AOP_SLLV:  res_o = src2_i << shamt_v;
            exe_isa_pkg::AOP_SRL:   res_o = src2_i >> src1_i;
            exe_isa_pkg::AOP_SRLV:  res_o = src2_i >> shamt_v;
            exe_isa_pkg::AOP_SRA:   res_o = sra_full;
            exe_isa_pkg::AOP_SRAV:  res_o = sra_var;
            default:                res_o = '0;
        endcase
    end

    assign is_sub = (aluop_i == exe_isa_pkg::AOP_SUB) || (aluop_i == exe_isa_pkg::AOP_SUBU);

    // same-sign add or mixed-sign subtract flipping the sign
    assign add_ov = (src1_i[W-1] == src2_i[W-1]) && (sum[W-1] != src1_i[W-1]);
    assign sub_ov = (src1_i[W-1] != src2_i[W-1]) && (diff[W-1] != src1_i[W-1]);

    assign ov_o = is_sub ? sub_ov : add_ov;

endmodule

`default_nettype wire

/* hw/exe_muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module exe_muldiv (
    input  logic                   cpu_clk_50M,
    input  logic                   rst_n_i,
    input  logic                   mul_signed_i,
    input  exe_bus_pkg::word_t     src1_i,
    input  exe_bus_pkg::word_t     src2_i,
    input  exe_bus_pkg::div_req_t  div_req_i,
    output exe_bus_pkg::hilo_u     mul_res_o,
    output exe_bus_pkg::hilo_u     div_res_o,
    output logic                   div_ready_o
);

    localparam int W     = `EXE_WORD_W;
    localparam int CNT_W = $clog2(`EXE_DIV_STEPS + 1);

    localparam logic [1:0] DIV_IDLE = 2'd0;
    localparam logic [1:0] DIV_ZERO = 2'd1;
    localparam logic [1:0] DIV_ON   = 2'd2;
    localparam logic [1:0] DIV_END  = 2'd3;

    logic [`EXE_DWORD_W-1:0] mul_a;
    logic [`EXE_DWORD_W-1:0] mul_b;

    // one multiplier, sign-extended only for MULT
    assign mul_a = {{W{mul_signed_i & src1_i[W-1]}}, src1_i};
    assign mul_b = {{W{mul_signed_i & src2_i[W-1]}}, src2_i};
    assign mul_res_o.prod = mul_a * mul_b;

    logic [1:0]          state;
    logic [CNT_W-1:0]    cnt;
    logic                cnt_done;
    logic                ready_r;
    exe_bus_pkg::hilo_u  res_r;
    exe_bus_pkg::word_t  dvd_q;     // dividend shifts out the top, quotient in the bottom
    exe_bus_pkg::word_t  rem_r;
    exe_bus_pkg::word_t  dsr_r;
    logic                neg_q;
    logic                neg_r;

    exe_bus_pkg::word_t  a_abs;
    exe_bus_pkg::word_t  b_abs;
    logic [W+1:0]        trial;
    logic [W+1:0]        dsr_x2;
    logic [W+1:0]        dsr_x3;
    logic [W+2:0]        t1;
    logic [W+2:0]        t2;
    logic [W+2:0]        t3;
    logic [1:0]          q_dig;
    exe_bus_pkg::word_t  rem_nxt;

    assign a_abs = (div_req_i.is_signed && div_req_i.dividend[W-1]) ?
                   -div_req_i.dividend : div_req_i.dividend;
    assign b_abs = (div_req_i.is_signed && div_req_i.divisor[W-1]) ?
                   -div_req_i.divisor : div_req_i.divisor;

    // remainder with the next two dividend bits, tried against 3d, 2d, d
    assign trial  = {rem_r, dvd_q[W-1 -: 2]};
    assign dsr_x2 = {1'b0, dsr_r, 1'b0};
    assign dsr_x3 = dsr_x2 + {2'b00, dsr_r};
    assign t3     = {1'b0, trial} - {1'b0, dsr_x3};
    assign t2     = {1'b0, trial} - {1'b0, dsr_x2};
    assign t1     = {1'b0, trial} - {3'b000, dsr_r};

    always_comb begin
        if (!t3[W+2]) begin
            q_dig   = 2'd3;
            rem_nxt = t3[W-1:0];
        end else if (!t2[W+2]) begin
            q_dig   = 2'd2;
            rem_nxt = t2[W-1:0];
        end else if (!t1[W+2]) begin
            q_dig   = 2'd1;
            rem_nxt = t1[W-1:0];
        end else begin
            q_dig   = 2'd0;
            rem_nxt = trial[W-1:0];   // below d, fits in a word
        end
    end

    assign cnt_done = (cnt == CNT_W'(`EXE_DIV_STEPS));

    always_ff @(posedge cpu_clk_50M) begin
        if (state == DIV_IDLE && div_req_i.start) begin
            dvd_q <= a_abs;
            rem_r <= '0;
            dsr_r <= b_abs;
            neg_q <= div_req_i.is_signed && (div_req_i.dividend[W-1] ^ div_req_i.divisor[W-1]);
            neg_r <= div_req_i.is_signed && div_req_i.dividend[W-1];
        end else if (state == DIV_ON && !cnt_done) begin
            dvd_q <= {dvd_q[W-3:0], q_dig};
            rem_r <= rem_nxt;
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        if (!rst_n_i) begin
            state   <= DIV_IDLE;
            cnt     <= '0;
            ready_r <= 1'b0;
            res_r   <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    ready_r <= 1'b0;
                    res_r   <= '0;
                    cnt     <= '0;
                    if (div_req_i.start) begin
                        state <= (div_req_i.divisor == '0) ? DIV_ZERO : DIV_ON;
                    end
                end
                DIV_ZERO: begin
                    res_r   <= '0;   // divide by zero yields zero
                    ready_r <= 1'b1;
                    state   <= DIV_END;
                end
                DIV_ON: begin
                    if (!cnt_done) begin
                        cnt <= cnt + 1'b1;
                    end else begin
                        res_r.hl.hi <= neg_r ? -rem_r : rem_r;   // sign of dividend
                        res_r.hl.lo <= neg_q ? -dvd_q : dvd_q;
                        ready_r     <= 1'b1;
                        state       <= DIV_END;
                    end
                end
                default: begin
                    if (!div_req_i.start) begin
                        state   <= DIV_IDLE;
                        ready_r <= 1'b0;
                        res_r   <= '0;
                    end
                end
            endcase
        end
    end

    assign div_res_o   = res_r;
    assign div_ready_o = ready_r;

    a_ready_in_end: assert property (@(posedge cpu_clk_50M) disable iff (!rst_n_i)
        ready_r |-> (state == DIV_END))
        else $error("exe_muldiv: ready outside the end state");

    // operands must be held by upstream while the loop runs
    a_ops_held: assert property (@(posedge cpu_clk_50M) disable iff (!rst_n_i)
        (state == DIV_ON && div_req_i.start) |->
            ($stable(div_req_i.dividend) && $stable(div_req_i.divisor)))
        else $error("exe_muldiv: operands changed during a divide");

endmodule

`default_nettype wire

/* hw/exe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl (
    input  logic                   rst_n_i,
    input  exe_bus_pkg::exe_req_t  req_i,
    input  exe_bus_pkg::word_t     alu_res_i,
    input  logic                   alu_ov_i,
    input  exe_bus_pkg::hilo_u     mul_res_i,
    input  exe_bus_pkg::hilo_u     div_res_i,
    input  logic                   div_ready_i,
    output exe_bus_pkg::div_req_t  div_req_o,
    output logic                   mul_signed_o,
    output exe_bus_pkg::exe_rsp_t  rsp_o,
    output logic                   stall_o
);

    exe_isa_pkg::alutype_e alutype;
    logic                  is_div;
    logic                  ov_inst;

    always_comb begin
        case (req_i.aluop)
            exe_isa_pkg::AOP_AND, exe_isa_pkg::AOP_ANDI, exe_isa_pkg::AOP_OR,
            exe_isa_pkg::AOP_ORI, exe_isa_pkg::AOP_XOR, exe_isa_pkg::AOP_XORI,
            exe_isa_pkg::AOP_NOR, exe_isa_pkg::AOP_LUI:
                alutype = exe_isa_pkg::ATYPE_LOGIC;
            exe_isa_pkg::AOP_ADD, exe_isa_pkg::AOP_ADDI, exe_isa_pkg::AOP_ADDU,
            exe_isa_pkg::AOP_ADDIU, exe_isa_pkg::AOP_SUB, exe_isa_pkg::AOP_SUBU,
            exe_isa_pkg::AOP_SLT, exe_isa_pkg::AOP_SLTI, exe_isa_pkg::AOP_SLTU,
            exe_isa_pkg::AOP_SLTIU:
                alutype = exe_isa_pkg::ATYPE_ARITH;
            exe_isa_pkg::AOP_SLL, exe_isa_pkg::AOP_SRL, exe_isa_pkg::AOP_SRA,
            exe_isa_pkg::AOP_SLLV, exe_isa_pkg::AOP_SRLV, exe_isa_pkg::AOP_SRAV:
                alutype = exe_isa_pkg::ATYPE_SHIFT;
            exe_isa_pkg::AOP_MULT, exe_isa_pkg::AOP_MULTU,
            exe_isa_pkg::AOP_DIV, exe_isa_pkg::AOP_DIVU:
                alutype = exe_isa_pkg::ATYPE_HILO;
            default:
                alutype = exe_isa_pkg::ATYPE_NONE;
        endcase
    end

    assign is_div  = (req_i.aluop == exe_isa_pkg::AOP_DIV) ||
                     (req_i.aluop == exe_isa_pkg::AOP_DIVU);
    assign ov_inst = (req_i.aluop == exe_isa_pkg::AOP_ADD) ||
                     (req_i.aluop == exe_isa_pkg::AOP_ADDI) ||
                     (req_i.aluop == exe_isa_pkg::AOP_SUB);

    // hold upstream until the divider reports ready
    assign stall_o      = rst_n_i && is_div && !div_ready_i;
    assign mul_signed_o = (req_i.aluop == exe_isa_pkg::AOP_MULT);

    always_comb begin
        div_req_o = '0;
        if (rst_n_i && is_div) begin
            div_req_o.start     = !div_ready_i;
            div_req_o.is_signed = (req_i.aluop == exe_isa_pkg::AOP_DIV);
            div_req_o.dividend  = req_i.src1;
            div_req_o.divisor   = req_i.src2;
        end
    end

    always_comb begin
        rsp_o = '0;
        if (rst_n_i) begin
            rsp_o.wa   = req_i.wa;
            rsp_o.wreg = req_i.wreg;
            case (alutype)
                exe_isa_pkg::ATYPE_LOGIC, exe_isa_pkg::ATYPE_ARITH,
                exe_isa_pkg::ATYPE_SHIFT: rsp_o.wd = alu_res_i;
                exe_isa_pkg::ATYPE_HILO: begin
                    rsp_o.whilo = 1'b1;
                    rsp_o.hilo  = is_div ? div_res_i : mul_res_i;
                end
                default: rsp_o.wd = '0;
            endcase
            rsp_o.ov = alu_ov_i && ov_inst;   // trap only on the signed forms
        end
    end

endmodule

`default_nettype wire

/* hw/exe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  logic                   cpu_clk_50M,
    input  logic                   rst_n_i,
    input  exe_bus_pkg::exe_req_t  req_i,
    output exe_bus_pkg::exe_rsp_t  rsp_o,
    output logic                   stall_o
);

    exe_bus_pkg::word_t     alu_res;
    logic                   alu_ov;
    exe_bus_pkg::hilo_u     mul_res;
    exe_bus_pkg::hilo_u     div_res;
    logic                   div_ready;
    exe_bus_pkg::div_req_t  div_req;
    logic                   mul_signed;

    exe_ctrl u_exe_ctrl (
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .alu_res_i    (alu_res),
        .alu_ov_i     (alu_ov),
        .mul_res_i    (mul_res),
        .div_res_i    (div_res),
        .div_ready_i  (div_ready),
        .div_req_o    (div_req),
        .mul_signed_o (mul_signed),
        .rsp_o        (rsp_o),
        .stall_o      (stall_o)
    );

    exe_alu u_exe_alu (
        .aluop_i (req_i.aluop),
        .src1_i  (req_i.src1),
        .src2_i  (req_i.src2),
        .res_o   (alu_res),
        .ov_o    (alu_ov)
    );

    // multiplier is combinational, divider holds until released
    exe_muldiv u_exe_muldiv (
        .cpu_clk_50M  (cpu_clk_50M),
        .rst_n_i      (rst_n_i),
        .mul_signed_i (mul_signed),
        .src1_i       (req_i.src1),
        .src2_i       (req_i.src2),
        .div_req_i    (div_req),
        .mul_res_o    (mul_res),
        .div_res_o    (div_res),
        .div_ready_o  (div_ready)
    );

endmodule

`default_nettype wire

/* verification/exe_tb_ref.svh */
`ifndef EXE_TB_REF_SVH
`define EXE_TB_REF_SVH

// galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// bit by bit; mode 0 left, 1 logical right, 2 arithmetic right
function automatic exe_bus_pkg::word_t shift_ref(input exe_bus_pkg::word_t v,
                                                 input logic [31:0] sh, input int mode);
    exe_bus_pkg::word_t r;
    int                 s;
    s = (sh > 32'd63) ? 63 : int'(sh[5:0]);
    for (int i = 0; i < `EXE_WORD_W; i++) begin
        if (mode == 0) begin
            r[i] = (i >= s) ? v[i - s] : 1'b0;
        end else begin
            r[i] = (i + s < `EXE_WORD_W) ? v[i + s] : ((mode == 2) && v[`EXE_WORD_W-1]);
        end
    end
    return r;
endfunction

// magnitudes first, then quotient and remainder signs
function automatic exe_bus_pkg::hilo_u div_ref(input exe_bus_pkg::word_t a,
                                               input exe_bus_pkg::word_t b, input logic sgn);
    exe_bus_pkg::hilo_u h;
    exe_bus_pkg::word_t ua;
    exe_bus_pkg::word_t ub;
    h = '0;
    if (b == '0) begin
        return h;
    end
    ua = (sgn && a[31]) ? (32'd0 - a) : a;
    ub = (sgn && b[31]) ? (32'd0 - b) : b;
    h.hl.lo = ua / ub;
    h.hl.hi = ua % ub;
    if (sgn && (a[31] != b[31])) begin
        h.hl.lo = 32'd0 - h.hl.lo;
    end
    if (sgn && a[31]) begin
        h.hl.hi = 32'd0 - h.hl.hi;   // follows the dividend
    end
    return h;
endfunction

function automatic exe_bus_pkg::exe_rsp_t ref_rsp(input exe_bus_pkg::exe_req_t r);
    exe_bus_pkg::exe_rsp_t e;
    longint                a;
    longint                b;
    longint                s;
    longint unsigned       ua;
    longint unsigned       ub;
    e      = '0;
    e.wa   = r.wa;
    e.wreg = r.wreg;
    a      = longint'($signed(r.src1));
    b      = longint'($signed(r.src2));
    ua     = r.src1;
    ub     = r.src2;
    case (r.aluop)
        exe_isa_pkg::AOP_AND, exe_isa_pkg::AOP_ANDI: e.wd = r.src1 & r.src2;
        exe_isa_pkg::AOP_OR, exe_isa_pkg::AOP_ORI:   e.wd = r.src1 | r.src2;
        exe_isa_pkg::AOP_XOR, exe_isa_pkg::AOP_XORI: e.wd = r.src1 ^ r.src2;
        exe_isa_pkg::AOP_NOR:                        e.wd = ~(r.src1 | r.src2);
        exe_isa_pkg::AOP_LUI:                        e.wd = r.src2;
        exe_isa_pkg::AOP_ADD, exe_isa_pkg::AOP_ADDI, exe_isa_pkg::AOP_ADDU,
        exe_isa_pkg::AOP_ADDIU, exe_isa_pkg::AOP_SUB, exe_isa_pkg::AOP_SUBU: begin
            s    = (r.aluop inside {exe_isa_pkg::AOP_SUB, exe_isa_pkg::AOP_SUBU}) ? a - b : a + b;
            e.wd = s[31:0];
            e.ov = (r.aluop inside {exe_isa_pkg::AOP_ADD, exe_isa_pkg::AOP_ADDI,
                                    exe_isa_pkg::AOP_SUB}) &&
                   ((s > 64'sd2147483647) || (s < -64'sd2147483648));
        end
        exe_isa_pkg::AOP_SLT, exe_isa_pkg::AOP_SLTI:   e.wd = {31'd0, (a < b)};
        exe_isa_pkg::AOP_SLTU, exe_isa_pkg::AOP_SLTIU: e.wd = {31'd0, (ua < ub)};
        exe_isa_pkg::AOP_SLL:  e.wd = shift_ref(r.src2, r.src1, 0);
        exe_isa_pkg::AOP_SRL:  e.wd = shift_ref(r.src2, r.src1, 1);
        exe_isa_pkg::AOP_SRA:  e.wd = shift_ref(r.src2, r.src1, 2);
        exe_isa_pkg::AOP_SLLV: e.wd = shift_ref(r.src2, {27'd0, r.src1[4:0]}, 0);
        exe_isa_pkg::AOP_SRLV: e.wd = shift_ref(r.src2, {27'd0, r.src1[4:0]}, 1);
        exe_isa_pkg::AOP_SRAV: e.wd = shift_ref(r.src2, {27'd0, r.src1[4:0]}, 2);
        exe_isa_pkg::AOP_MULT: begin
            e.whilo     = 1'b1;
            e.hilo.prod = a * b;
        end
        exe_isa_pkg::AOP_MULTU: begin
            e.whilo     = 1'b1;
            e.hilo.prod = ua * ub;
        end
        exe_isa_pkg::AOP_DIV, exe_isa_pkg::AOP_DIVU: begin
            e.whilo = 1'b1;
            e.hilo  = div_ref(r.src1, r.src2, r.aluop == exe_isa_pkg::AOP_DIV);
        end
        default: ;
    endcase
    return e;
endfunction

`endif

/* verification/exe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_cfg.svh"

module exe_tb;

    localparam int N_ALU   = 150;
    localparam int N_OV    = 12;
    localparam int N_MUL   = 24;
    localparam int N_DIV   = 24;
    localparam int N_TESTS = 1 + N_ALU + N_OV + N_MUL + N_DIV + 4;
    localparam int MAX_CYC = 5 + N_TESTS * 25;

    logic                  cpu_clk_50M;
    logic                  rst_n_i;
    exe_bus_pkg::exe_req_t req;
    exe_bus_pkg::exe_rsp_t rsp;
    logic                  stall;

    exe_bus_pkg::exe_rsp_t exp_rsp;
    string                 test_name;
    logic                  pending;
    logic                  req_is_div;
    logic [31:0]           lfsr;
    int                    cycles       = 0;
    int                    stall_cycles = 0;
    int                    errors       = 0;

    exe_isa_pkg::aluop_e alu_ops [24] = '{
        exe_isa_pkg::AOP_AND, exe_isa_pkg::AOP_ANDI, exe_isa_pkg::AOP_OR, exe_isa_pkg::AOP_ORI,
        exe_isa_pkg::AOP_XOR, exe_isa_pkg::AOP_XORI, exe_isa_pkg::AOP_NOR, exe_isa_pkg::AOP_LUI,
        exe_isa_pkg::AOP_ADD, exe_isa_pkg::AOP_ADDI, exe_isa_pkg::AOP_ADDU,
        exe_isa_pkg::AOP_ADDIU, exe_isa_pkg::AOP_SUB, exe_isa_pkg::AOP_SUBU,
        exe_isa_pkg::AOP_SLT, exe_isa_pkg::AOP_SLTI, exe_isa_pkg::AOP_SLTU,
        exe_isa_pkg::AOP_SLTIU, exe_isa_pkg::AOP_SLL, exe_isa_pkg::AOP_SRL,
        exe_isa_pkg::AOP_SRA, exe_isa_pkg::AOP_SLLV, exe_isa_pkg::AOP_SRLV, exe_isa_pkg::AOP_SRAV
    };
    exe_isa_pkg::aluop_e ov_ops [6] = '{
        exe_isa_pkg::AOP_ADD, exe_isa_pkg::AOP_ADDU, exe_isa_pkg::AOP_ADDI,
        exe_isa_pkg::AOP_ADDIU, exe_isa_pkg::AOP_SUB, exe_isa_pkg::AOP_SUBU
    };

    `include "exe_tb_ref.svh"

    exe_stage u_exe_stage (
        .cpu_clk_50M (cpu_clk_50M),
        .rst_n_i     (rst_n_i),
        .req_i       (req),
        .rsp_o       (rsp),
        .stall_o     (stall)
    );

    always #10 cpu_clk_50M = ~cpu_clk_50M;

    assign req_is_div = rst_n_i &&
                        (req.aluop inside {exe_isa_pkg::AOP_DIV, exe_isa_pkg::AOP_DIVU});

    task automatic stop_with_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_word(input string name, input exe_bus_pkg::word_t exp,
                              input exe_bus_pkg::word_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_hilo(input string name, input exe_bus_pkg::hilo_u exp,
                              input exe_bus_pkg::hilo_u act);
        if (act !== exp) begin
            stop_with_error($sformatf("[ERROR] %s: expected %h, actual %h",
                                      name, exp.prod, act.prod));
        end
    endtask

    task automatic check_addr(input string name, input logic [`EXE_REG_ADDR_W-1:0] exp,
                              input logic [`EXE_REG_ADDR_W-1:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_error($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_rsp(input string name, input exe_bus_pkg::exe_rsp_t e);
        check_addr({name, " wa"}, e.wa, rsp.wa);
        check_flag({name, " wreg"}, e.wreg, rsp.wreg);
        check_word({name, " wd"}, e.wd, rsp.wd);
        check_flag({name, " whilo"}, e.whilo, rsp.whilo);
        check_hilo({name, " hilo"}, e.hilo, rsp.hilo);
        check_flag({name, " ov"}, e.ov, rsp.ov);
    endtask

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic exe_bus_pkg::exe_req_t rand_req(input exe_isa_pkg::aluop_e op);
        exe_bus_pkg::exe_req_t r;
        r.aluop = op;
        r.src1  = take_bits(32);
        r.src2  = take_bits(32);
        r.wa    = `EXE_REG_ADDR_W'(take_bits(`EXE_REG_ADDR_W));
        r.wreg  = 1'(take_bits(1));
        if (op inside {exe_isa_pkg::AOP_SLL, exe_isa_pkg::AOP_SRL, exe_isa_pkg::AOP_SRA}) begin
            r.src1 = take_bits(6);   // sometimes past the word width
        end
        if (op == exe_isa_pkg::AOP_LUI) begin
            r.src2 = {16'(take_bits(16)), 16'h0000};
        end
        return r;
    endfunction

    task automatic apply(input string name, input logic rst, input exe_bus_pkg::exe_req_t r,
                         input exe_bus_pkg::exe_rsp_t e);
        @(posedge cpu_clk_50M);
        #1;
        rst_n_i   = rst;
        req       = r;
        exp_rsp   = e;
        test_name = name;
        pending   = 1'b1;
        wait (pending == 1'b0);
    endtask

    task automatic run_op(input string name, input exe_bus_pkg::exe_req_t r);
        apply(name, 1'b1, r, ref_rsp(r));
    endtask

    task automatic div_case(input string name, input exe_isa_pkg::aluop_e op,
                            input exe_bus_pkg::word_t a, input exe_bus_pkg::word_t b);
        exe_bus_pkg::exe_req_t r;
        r      = rand_req(op);
        r.src1 = a;
        r.src2 = b;
        run_op(name, r);
    endtask

    // compare just before the next rising edge
    always begin
        @(posedge cpu_clk_50M);
        #18;
        if (pending && stall && !req_is_div) begin
            stop_with_error($sformatf("%s: stall raised without a divide", test_name));
        end else if (pending && stall) begin
            stall_cycles++;
            if (stall_cycles > 40) begin
                stop_with_error($sformatf("%s: stall held for more than 40 cycles", test_name));
            end
        end else if (pending) begin
            if (req_is_div && stall_cycles == 0) begin
                stop_with_error($sformatf("%s: divide finished without a stall", test_name));
            end
            check_rsp(test_name, exp_rsp);
            stall_cycles = 0;
            pending      = 1'b0;
        end
    end

    always @(posedge cpu_clk_50M) begin
        cycles++;
        if (cycles > MAX_CYC) begin
            stop_with_error("timeout, the stage never finished the tests");
        end
    end

    initial begin
        exe_bus_pkg::exe_req_t r;
        exe_isa_pkg::aluop_e   op;
        exe_bus_pkg::word_t    p;
        exe_bus_pkg::word_t    p2;
        exe_bus_pkg::word_t    n;
        exe_bus_pkg::word_t    n2;
        logic [7:0]            b8;
        cpu_clk_50M = 1'b0;
        rst_n_i     = 1'b0;
        req         = '0;
        exp_rsp     = '0;
        pending     = 1'b0;
        lfsr        = 32'h23851995;

        // a pending divide under reset must stay invisible
        r = rand_req(exe_isa_pkg::AOP_DIV);
        for (int i = 0; i < 5; i++) begin
            apply("reset", 1'b0, r, '0);
        end
        apply("after reset", 1'b1, '0, '0);

        for (int i = 0; i < N_ALU; i++) begin
            op = alu_ops[int'(take_bits(5) % 24)];
            run_op($sformatf("alu %0d %s", i, op.name()), rand_req(op));
        end

        for (int k = 0; k < 2; k++) begin
            p  = {4'h7, 28'(take_bits(28))};
            p2 = {4'h7, 28'(take_bits(28))};
            n  = {4'h8, 28'(take_bits(28))};
            n2 = {4'h8, 28'(take_bits(28))};
            for (int j = 0; j < 6; j++) begin
                r = rand_req(ov_ops[j]);
                if (ov_ops[j] inside {exe_isa_pkg::AOP_SUB, exe_isa_pkg::AOP_SUBU}) begin
                    r.src1 = (k == 0) ? p : n;
                    r.src2 = (k == 0) ? n : p;   // mixed signs
                end else begin
                    r.src1 = (k == 0) ? p : n;
                    r.src2 = (k == 0) ? p2 : n2;
                end
                run_op($sformatf("overflow %0d %s", k, ov_ops[j].name()), r);
            end
        end

        for (int i = 0; i < N_MUL; i++) begin
            op = (i % 2 == 0) ? exe_isa_pkg::AOP_MULT : exe_isa_pkg::AOP_MULTU;
            run_op($sformatf("mul %0d %s", i, op.name()), rand_req(op));
        end

        // consecutive divides, divider must go idle between them
        for (int i = 0; i < N_DIV; i++) begin
            op = (i % 2 == 0) ? exe_isa_pkg::AOP_DIV : exe_isa_pkg::AOP_DIVU;
            r  = rand_req(op);
            if (take_bits(1) == 32'd1) begin
                b8     = 8'(take_bits(8));
                r.src2 = {{24{b8[7]}}, b8};
            end
            run_op($sformatf("div %0d %s", i, op.name()), r);
        end
        div_case("div by zero", exe_isa_pkg::AOP_DIV, 32'h1234_5678, 32'h0);
        div_case("divu by zero", exe_isa_pkg::AOP_DIVU, 32'hfedc_ba98, 32'h0);
        div_case("div min by -1", exe_isa_pkg::AOP_DIV, 32'h8000_0000, 32'hffff_ffff);
        div_case("div -7 by 2", exe_isa_pkg::AOP_DIV, 32'hffff_fff9, 32'h2);

        if (errors == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_with_error("errors were recorded during the run");
        end
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hw
+incdir+verification
hw/exe_isa_pkg.sv
hw/exe_bus_pkg.sv
hw/exe_alu.sv
hw/exe_muldiv.sv
hw/exe_ctrl.sv
hw/exe_stage.sv
verification/exe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the execute stage testbench with verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f compile.f --top-module exe_tb \
    -o exe_tb_sim --Mdir obj_dir

if ./obj_dir/exe_tb_sim 2>&1 | tee /dev/stderr | grep -q "^Finished with no errors$"; then
    echo "simulation passed"
else
    echo "simulation FAILED"
    exit 1
fi
